/* dv/arb_checker.sv */
// Reference model of the arbiter, mirrors APB weight writes and compares grant after every edge
`timescale 1ns/1ns

module arb_checker #(
    parameter int NUM_REQ = arb_pkg::NUM_REQ
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  apb_regs_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_regs_pkg::apb_data_t pwdata,
    input  logic [NUM_REQ-1:0]      req,
    input  logic [NUM_REQ-1:0]      grant,
    output int                      grant_errors
);
    import arb_pkg::*;
    import apb_regs_pkg::*;

    typedef logic [NUM_REQ*CREDIT_W-1:0] credit_vec_t;
    typedef logic [NUM_REQ*WEIGHT_W-1:0] weight_vec_t;

    weight_vec_t        weight_mirror;
    credit_vec_t        credit_model;
    logic [NUM_REQ-1:0] exp_grant;

    // Credits after one edge, and the grant that edge registers
    function automatic logic [NUM_REQ-1:0] predict_grant(
        input  weight_vec_t        w,
        input  credit_vec_t        c,
        input  logic [NUM_REQ-1:0] prev_grant,
        input  logic [NUM_REQ-1:0] r,
        output credit_vec_t        c_next
    );
        logic [NUM_REQ-1:0] g;
        int                 best;
        int                 total;
        g      = '0;
        best   = -1;
        c_next = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (r[i]) begin
                if (prev_grant[i]) begin
                    total = int'(w[i*WEIGHT_W +: WEIGHT_W]);
                end else begin
                    total = int'(c[i*CREDIT_W +: CREDIT_W]) + int'(w[i*WEIGHT_W +: WEIGHT_W]);
                end
                if (total > int'(CREDIT_MAX)) begin
                    total = int'(CREDIT_MAX);
                end
                c_next[i*CREDIT_W +: CREDIT_W] = credit_t'(total);
                // Strictly larger only, so ties stay with the lower index
                if (total > best) begin
                    best = total;
                    g    = '0;
                    g[i] = 1'b1;
                end
            end
        end
        return g;
    endfunction

    // Register map decode: aligned, on the stride, inside the requester range
    function automatic bit weight_index(input apb_addr_t addr, output int idx);
        int off;
        off = int'(addr) - int'(WEIGHT_BASE);
        idx = off / int'(WEIGHT_STRIDE);
        return (off >= 0) && (addr[1:0] == 2'b00) && (off % int'(WEIGHT_STRIDE) == 0)
            && (idx < NUM_REQ);
    endfunction

    initial grant_errors = 0;

    always @(posedge clk or negedge rst_n) begin
        credit_vec_t c_next;
        int          idx;
        if (!rst_n) begin
            credit_model  = '0;
            weight_mirror = '0;
            exp_grant     = '0;
        end else begin
            // grant still holds the value registered at the previous edge
            if (grant !== exp_grant) begin
                grant_errors++;
                $display("[ERROR] grant: expected %h, got %h at %0t", exp_grant, grant, $time);
            end
            exp_grant    = predict_grant(weight_mirror, credit_model, exp_grant, req, c_next);
            credit_model = c_next;
            // New weight counts from the next edge on
            if (psel && penable && pwrite && weight_index(paddr, idx)) begin
                weight_mirror[idx*WEIGHT_W +: WEIGHT_W] = pwdata[WEIGHT_W-1:0];
            end
        end
    end

endmodule

/* dv/arb_tb.sv */
// Testbench top for the weighted arbiter, drives APB and requests and prints the run summary
`timescale 1ns/1ns

module arb_tb;
    import arb_pkg::*;
    import apb_regs_pkg::*;

    localparam int APB_CYCLES   = 3;
    localparam int SHARE_CYCLES = 64;
    localparam int TIE_CYCLES   = 16;
    localparam int RAND_CYCLES  = 300;
    localparam int SAT_CYCLES   = 400;
    // Worst case assumes an APB write on every random step
    localparam int MAX_CYCLES = 2 + APB_CYCLES * (NUM_REQ * 9 + 4) + NUM_REQ * 14
                              + SHARE_CYCLES + TIE_CYCLES + APB_CYCLES * RAND_CYCLES
                              + SAT_CYCLES + 100;

    logic               clk;
    logic               rst_n;
    apb_addr_t          paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_data_t          pwdata;
    apb_data_t          prdata;
    logic               pready;
    logic               pslverr;
    logic [NUM_REQ-1:0] req;
    logic [NUM_REQ-1:0] grant;
    apb_state_t         bus_phase;
    logic               count_wins;
    int                 grant_errors;
    int                 apb_errors;
    int                 test_errors;
    int                 cycle_count = 0;
    int                 win_count [NUM_REQ];

    weighted_arbiter_top #(.NUM_REQ(NUM_REQ)) dut (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .req(req), .grant(grant)
    );

    arb_checker #(.NUM_REQ(NUM_REQ)) u_checker (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .req(req), .grant(grant),
        .grant_errors(grant_errors)
    );

    // Bus control lines follow the phase of the APB task
    assign psel    = (bus_phase != APB_IDLE);
    assign penable = (bus_phase == APB_ACCESS);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Grant of the cycle that just ended
    always @(posedge clk) begin
        if (count_wins) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (grant[i]) win_count[i]++;
            end
        end
    end

    // Setup then access; called right after a falling edge
    task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        bus_phase = APB_SETUP;
        paddr     = addr;
        pwrite    = write;
        pwdata    = wdata;
        @(negedge clk);
        bus_phase = APB_ACCESS;
        // No wait states, so the access completes in this cycle
        if (pready !== 1'b1) begin
            apb_errors++;
            $display("[ERROR] pready at %h: expected %h, got %h", addr, 1'b1, pready);
        end
        rdata     = prdata;
        err       = pslverr;
        @(negedge clk);
        bus_phase = APB_IDLE;
        pwrite    = 1'b0;
    endtask

    task automatic write_weight(input int idx, input int value);
        apb_data_t rd;
        logic      err;
        apb_transfer(WEIGHT_BASE + apb_addr_t'(idx) * WEIGHT_STRIDE, 1'b1,
                     apb_data_t'(value), rd, err);
        if (err !== 1'b0) begin
            apb_errors++;
            $display("Write to weight register %0d was rejected with pslverr", idx);
        end
    endtask

    task automatic check_read(input apb_addr_t addr, input apb_data_t expected,
                              input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_transfer(addr, 1'b0, '0, rd, err);
        if (rd !== expected) begin
            apb_errors++;
            $display("[ERROR] prdata at %h: expected %h, got %h", addr, expected, rd);
        end
        if (err !== exp_err) begin
            apb_errors++;
            $display("Wrong pslverr on read of address %h, expected %0b", addr, exp_err);
        end
    endtask

    task automatic check_bad_write(input apb_addr_t addr);
        apb_data_t rd;
        logic      err;
        apb_transfer(addr, 1'b1, 32'h0000_000F, rd, err);
        if (err !== 1'b1) begin
            apb_errors++;
            $display("No pslverr on write to unmapped address %h", addr);
        end
    endtask

    initial begin
        void'($urandom(48270));
        rst_n      = 1'b0;
        paddr      = '0;
        pwrite     = 1'b0;
        pwdata     = '0;
        req        = '0;
        bus_phase  = APB_IDLE;
        count_wins = 1'b0;
        apb_errors = 0;
        test_errors = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Weights come out of reset as zero
        for (int i = 0; i < NUM_REQ; i++) begin
            check_read(WEIGHT_BASE + apb_addr_t'(i) * WEIGHT_STRIDE, '0, 1'b0);
        end

        // Only the low 4 bits are kept
        for (int i = 0; i < NUM_REQ; i++) begin
            write_weight(i, 32'hABCD_EF00 | (9 + i));
        end
        for (int i = 0; i < NUM_REQ; i++) begin
            check_read(WEIGHT_BASE + apb_addr_t'(i) * WEIGHT_STRIDE, apb_data_t'(9 + i), 1'b0);
        end
        check_bad_write(WEIGHT_BASE + apb_addr_t'(NUM_REQ) * WEIGHT_STRIDE);
        check_bad_write(WEIGHT_BASE + 8'h02);
        check_read(WEIGHT_BASE + apb_addr_t'(NUM_REQ) * WEIGHT_STRIDE, '0, 1'b1);
        check_read(WEIGHT_BASE + 8'h02, '0, 1'b1);
        for (int i = 0; i < NUM_REQ; i++) begin
            check_read(WEIGHT_BASE + apb_addr_t'(i) * WEIGHT_STRIDE, apb_data_t'(9 + i), 1'b0);
        end

        // One requester at a time, weight zero first
        for (int i = 0; i < NUM_REQ; i++) begin
            write_weight(i, (i == 0) ? 0 : 4 * i + 3);
            req    = '0;
            req[i] = 1'b1;
            repeat (12) @(negedge clk);
            req = '0;
            repeat (2) @(negedge clk);
        end

        for (int i = 0; i < NUM_REQ; i++) begin
            write_weight(i, 2 * i + 1);
            win_count[i] = 0;
        end
        count_wins = 1'b1;
        req        = '1;
        repeat (SHARE_CYCLES) @(negedge clk);
        count_wins = 1'b0;
        if (win_count[NUM_REQ-1] <= win_count[0]) begin
            test_errors++;
            $display("Highest weight won %0d times, no more than lowest weight with %0d",
                     win_count[NUM_REQ-1], win_count[0]);
        end

        // Equal weights exercise the tie rule
        req = '0;
        @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            write_weight(i, 4);
        end
        req = '1;
        repeat (TIE_CYCLES) @(negedge clk);

        for (int step = 0; step < RAND_CYCLES; step++) begin
            if ($urandom_range(15) == 0) begin
                write_weight(int'($urandom_range(NUM_REQ - 1)), int'($urandom_range(15)));
            end else begin
                req = req ^ NUM_REQ'($urandom & $urandom);
                @(negedge clk);
            end
        end

        // Requester 0 drops on its grant and comes back, the rest hold at weight 15
        req = '0;
        @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            write_weight(i, 15);
        end
        for (int step = 0; step < SAT_CYCLES; step++) begin
            req[NUM_REQ-1:1] = '1;
            req[0]           = ~grant[0];
            @(negedge clk);
        end
        req = '0;
        repeat (3) @(negedge clk);

        $display("Errors: grant %0d, apb %0d, other %0d", grant_errors, apb_errors, test_errors);
        if (grant_errors + apb_errors + test_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* rtl/apb_regs_pkg.sv */
// APB bus types and the weight register map, imported by the register block and the testbench
package apb_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Weight register i sits at WEIGHT_BASE + i * WEIGHT_STRIDE
    localparam apb_addr_t WEIGHT_BASE   = 8'h00;
    localparam apb_addr_t WEIGHT_STRIDE = 8'h04;

    // Phase of the current APB cycle
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

endpackage

/* rtl/arb_credit_cell.sv */
// Credit accumulator of a single requester, one instance per request line in the arbiter top
`timescale 1ns/1ns

module arb_credit_cell (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  arb_pkg::weight_t weight,
    input  logic             granted,
    output arb_pkg::credit_t credit_next
);
    import arb_pkg::*;

    credit_t             credit_q;
    logic [CREDIT_W:0]   sum;
    credit_t             sum_sat;

    // One spare bit catches the carry out of the add
    assign sum = {1'b0, credit_q} + {{(CREDIT_W + 1 - WEIGHT_W){1'b0}}, weight};

    assign sum_sat = sum[CREDIT_W] ? CREDIT_MAX : sum[CREDIT_W-1:0];

    always_comb begin
        if (!req) begin
            credit_next = '0;
        end else if (granted) begin
            // Winner of the last cycle starts over from its weight
            credit_next = credit_t'(weight);
        end else begin
            credit_next = sum_sat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= '0;
        end else begin
            credit_q <= credit_next;
        end
    end

endmodule

/* rtl/arb_grant_select.sv */
// Grant selector comparing requester credits and registering the one-hot grant of the arbiter
`timescale 1ns/1ns

module arb_grant_select #(
    parameter int NUM_REQ = arb_pkg::NUM_REQ
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [NUM_REQ-1:0]                   req,
    input  logic [NUM_REQ*arb_pkg::CREDIT_W-1:0] credits,
    output logic [NUM_REQ-1:0]                   grant
);
    import arb_pkg::*;

    credit_t              credit_arr [NUM_REQ];
    credit_t              best_credit;
    logic                 found;
    logic [NUM_REQ-1:0]   winner;

    for (genvar i = 0; i < NUM_REQ; i++) begin : g_unpack
        assign credit_arr[i] = credits[i*CREDIT_W +: CREDIT_W];
    end

    // Linear scan over requesting entries
    // Strict compare keeps the lowest index on a tie
    always_comb begin
        best_credit = '0;
        found       = 1'b0;
        winner      = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req[i] && (!found || (credit_arr[i] > best_credit))) begin
                best_credit = credit_arr[i];
                found       = 1'b1;
                winner      = '0;
                winner[i]   = 1'b1;
            end
        end
    end

    // Winner stays zero when nothing requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= winner;
        end
    end

endmodule

/* rtl/arb_pkg.sv */
// Arbitration widths and types, imported by the arbiter RTL and the testbench checker
package arb_pkg;

    // Requester count used when the top level is not overridden
    localparam int NUM_REQ = 4;

    // Bits of a programmed weight
    localparam int WEIGHT_W = 4;

    // Bits of an accumulated credit
    localparam int CREDIT_W = 16;

    // Credit added per cycle while a request is held
    typedef logic [WEIGHT_W-1:0] weight_t;

    // Accumulated credit of one requester
    typedef logic [CREDIT_W-1:0] credit_t;

    // Saturation ceiling of the accumulator
    localparam credit_t CREDIT_MAX = '1;

endpackage

/* rtl/arb_weight_regs.sv */
// APB slave storing one weight per requester and driving the weights into the arbiter core
`timescale 1ns/1ns

module arb_weight_regs #(
    parameter int NUM_REQ = arb_pkg::NUM_REQ
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  apb_regs_pkg::apb_addr_t              paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  apb_regs_pkg::apb_data_t              pwdata,
    output apb_regs_pkg::apb_data_t              prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [NUM_REQ*arb_pkg::WEIGHT_W-1:0] weights
);
    import arb_pkg::*;
    import apb_regs_pkg::*;

    apb_state_t          phase;
    logic [APB_ADDR_W:0] offset;
    apb_addr_t           reg_idx;
    logic                addr_ok;
    logic                wr_en;
    weight_t             rd_weight;
    weight_t             weights_q [NUM_REQ];

    // No wait states
    assign pready = 1'b1;

    always_comb begin
        if (!psel) begin
            phase = APB_IDLE;
        end else if (!penable) begin
            phase = APB_SETUP;
        end else begin
            phase = APB_ACCESS;
        end
    end

    // Extra top bit flags an address below the register window
    assign offset  = {1'b0, paddr} - {1'b0, WEIGHT_BASE};
    assign reg_idx = offset[APB_ADDR_W-1:0] / WEIGHT_STRIDE;

    assign addr_ok = !offset[APB_ADDR_W]
                  && (paddr[1:0] == 2'b00)
                  && ((offset[APB_ADDR_W-1:0] % WEIGHT_STRIDE) == '0)
                  && (int'(reg_idx) < NUM_REQ);

    assign wr_en = (phase == APB_ACCESS) && pwrite && addr_ok;

    always_comb begin
        rd_weight = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (addr_ok && (reg_idx == apb_addr_t'(i))) begin
                rd_weight = weights_q[i];
            end
        end
    end

    // Read data and error are captured in setup so they are valid throughout access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            prdata  <= '0;
            pslverr <= 1'b0;
            if (phase == APB_SETUP) begin
                pslverr <= !addr_ok;
                if (!pwrite && addr_ok) begin
                    prdata <= apb_data_t'(rd_weight);
                end
            end
        end
    end

    // Write lands on the edge that closes the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                weights_q[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (reg_idx == apb_addr_t'(i)) begin
                    weights_q[i] <= pwdata[WEIGHT_W-1:0];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_REQ; i++) begin : g_flat
        assign weights[i*WEIGHT_W +: WEIGHT_W] = weights_q[i];
    end

endmodule

/* rtl/weighted_arbiter_top.sv */
// Weighted credit arbiter top with APB weight programming, instantiated by the testbench as dut
`timescale 1ns/1ns

module weighted_arbiter_top #(
    parameter int NUM_REQ = arb_pkg::NUM_REQ
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // APB slave port for the weight registers
    input  apb_regs_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_regs_pkg::apb_data_t pwdata,
    output apb_regs_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,

    input  logic [NUM_REQ-1:0]      req,
    output logic [NUM_REQ-1:0]      grant
);
    import arb_pkg::*;

    logic [NUM_REQ*WEIGHT_W-1:0] weights;
    logic [NUM_REQ*CREDIT_W-1:0] credits;

    arb_weight_regs #(
        .NUM_REQ (NUM_REQ)
    ) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .weights (weights)
    );

    // Cell i sees its own slice of weight and credit, plus its grant bit
    for (genvar i = 0; i < NUM_REQ; i++) begin : g_cell
        arb_credit_cell u_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .req         (req[i]),
            .weight      (weights[i*WEIGHT_W +: WEIGHT_W]),
            .granted     (grant[i]),
            .credit_next (credits[i*CREDIT_W +: CREDIT_W])
        );
    end

    arb_grant_select #(
        .NUM_REQ (NUM_REQ)
    ) u_select (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .credits (credits),
        .grant   (grant)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the arbiter testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module arb_tb -f sim.f -o arb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/arb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* sim.f */
rtl/arb_pkg.sv
rtl/apb_regs_pkg.sv
rtl/arb_weight_regs.sv
rtl/arb_credit_cell.sv
rtl/arb_grant_select.sv
rtl/weighted_arbiter_top.sv
dv/arb_checker.sv
dv/arb_tb.sv
